// ==== all.f ====
src/isaPkg.sv
src/pipePkg.sv
src/ctrlBus.sv
src/pipeCtrl.sv
src/regFile.sv
src/execUnit.sv
src/dataRam.sv
src/execCore.sv
testbench/execCore_chk.sv
testbench/execCore_tb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module execCore_tb \
   -f all.f -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" sim.log; then
   exit 1
fi
exit 0

// ==== testbench/execCore_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module execCore_tb;

   logic        gclk;
   logic        grst;
   logic        advance;
   logic [31:0] instr;
   logic        wbValid;
   logic [4:0]  wbReg;
   logic [31:0] wbData;
   logic        memAccess;
   logic        memWrite;

   logic [31:0] regModel [32];
   logic [31:0] ramModel [256];
   logic [36:0] expQ [$];      // {register, data} in retire order
   logic [36:0] expEntry;
   logic [1:0]  issueMem;      // {access, write} of the word on instr
   logic [1:0]  execMem;       // Same for the instruction in execute
   logic [1:0]  expMemAtEdge;
   logic [1:0]  memAtEdge;
   logic        prefixOn;
   logic [15:0] prefixHi;
   logic        stallOn;
   logic        advAtEdge;
   logic        timedOut;
   int          seed = 68;
   int          errCount;
   int          checkCount;
   int          testCount;
   int          errMark;
   int          checkMark;
   string       testName;

   execCore #(.RamAddrBits(8)) i_dut (
      .gclk      (gclk),
      .grst      (grst),
      .advance   (advance),
      .instr     (instr),
      .wbValid   (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .memAccess (memAccess),
      .memWrite  (memWrite)
   );

   initial begin
      gclk = 1'b0;
      forever #50 gclk = ~gclk;
   end

   always @(posedge gclk) begin
      advAtEdge    <= advance;
      memAtEdge    <= {memAccess, memWrite};
      expMemAtEdge <= advance ? execMem : 2'b00;
      if (grst) begin
         execMem <= 2'b00;
      end else if (advance) begin
         execMem <= issueMem;  // Enters execute on this edge
      end
   end

   // Outputs settle after the rising edge
   always @(negedge gclk) begin
      if (!grst) begin
         assert (memAtEdge[1] == expMemAtEdge[1] &&
                 (!expMemAtEdge[1] || memAtEdge[0] == expMemAtEdge[0])) else begin
            $display("[ERROR] %s: expected memAccess/memWrite %b, actual %b", testName,
                     expMemAtEdge, memAtEdge);
            errCount++;
         end
         if (wbValid) begin
            assert (advAtEdge) else begin
               $display("Write-back of r%0d appeared although advance was low", wbReg);
               errCount++;
            end
            assert (expQ.size() > 0) else begin
               $display("Write-back of r%0d appeared with no instruction expecting it",
                        wbReg);
               errCount++;
            end
            if (expQ.size() > 0) begin
               expEntry = expQ.pop_front();
               checkCount++;
               assert (wbReg == expEntry[36:32] && wbData == expEntry[31:0]) else begin
                  $display("[ERROR] %s: expected r%0d = %h, actual r%0d = %h", testName,
                           expEntry[36:32], expEntry[31:0], wbReg, wbData);
                  errCount++;
               end
            end
         end
      end
   end

   function automatic logic [31:0] encR(input logic [5:0] op, input logic [4:0] rd,
                                        input logic [4:0] ra, input logic [4:0] rb);
      return {op, rd, ra, rb, 11'd0};
   endfunction

   function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rd,
                                        input logic [4:0] ra, input logic [15:0] imm);
      return {op, rd, ra, imm};
   endfunction

   function automatic logic [4:0] pickReg(input int span);
      return 5'($unsigned($random(seed)) % span);
   endfunction

   // Instruction semantics in program order
   task automatic model(input logic [31:0] w);
      logic [5:0]  op;
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic        writes;
      op = w[31:26];
      rd = w[25:21];
      a  = regModel[w[20:16]];
      b  = op[3] ? (prefixOn ? {prefixHi, w[15:0]} : {{16{w[15]}}, w[15:0]})
                 : regModel[w[15:11]];
      res      = '0;
      writes   = 1'b1;
      issueMem = 2'b00;
      casez (op)
         6'b00?00?: res = op[0] ? b - a : a + b;  // rsub is B minus A
         6'b10?0??: begin
            case (op[1:0])
               2'b00:   res = a | b;
               2'b01:   res = a & b;
               2'b10:   res = a ^ b;
               default: res = a & ~b;
            endcase
         end
         6'b100100: begin
            res = a >> 1;
            if (w[6:5] == 2'b00) begin
               res[31] = a[31];  // Arithmetic keeps the sign
            end
         end
         6'b11?010: begin
            res      = ramModel[8'((a + b) >> 2)];
            issueMem = 2'b10;
         end
         6'b111110: begin
            ramModel[8'((a + b) >> 2)] = regModel[rd];
            writes   = 1'b0;
            issueMem = 2'b11;
         end
         default:   writes = 1'b0;  // Prefix and unsupported opcodes
      endcase
      prefixOn = (op == isaPkg::OpImm);
      prefixHi = w[15:0];
      if (writes && rd != 5'd0) begin
         regModel[rd] = res;
         expQ.push_back({rd, res});
      end
   endtask

   task automatic issue(input logic [31:0] w);
      int k;
      k = stallOn ? int'($unsigned($random(seed)) % 4) : 0;
      repeat (k) begin
         advance = 1'b0;
         instr   = $random(seed);  // Ignored while stalled
         @(negedge gclk);
      end
      advance = 1'b1;
      instr   = w;
      model(w);
      @(negedge gclk);
   endtask

   task automatic loadConst(input logic [4:0] rd, input logic [31:0] val);
      issue(encI(isaPkg::OpImm, 5'd0, 5'd0, val[31:16]));
      issue(encI(isaPkg::OpAdd | 6'o10, rd, 5'd0, val[15:0]));
   endtask

   task automatic randArith(input int n);
      logic [5:0] op;
      repeat (n) begin
         op = isaPkg::OpAdd | 6'($unsigned($random(seed)) & 32'o11);
         issue(op[3] ? encI(op, pickReg(9), pickReg(9), 16'($random(seed)))
                     : encR(op, pickReg(9), pickReg(9), pickReg(9)));
      end
   endtask

   task automatic randLogic(input int n);
      logic [5:0] op;
      logic [1:0] kind;
      repeat (n) begin
         op   = isaPkg::OpLogic | 6'($unsigned($random(seed)) & 32'o13);
         kind = 2'($unsigned($random(seed)) % 3);
         if ($random(seed) & 1) begin
            issue(encI(isaPkg::OpShift, pickReg(9), pickReg(9), {9'd0, kind, 5'd0}));
         end else begin
            issue(op[3] ? encI(op, pickReg(9), pickReg(9), 16'($random(seed)))
                        : encR(op, pickReg(9), pickReg(9), pickReg(9)));
         end
      end
   endtask

   task automatic depChain(input int n);
      logic [4:0] prev1;
      logic [4:0] prev2;
      logic [4:0] rd;
      logic [5:0] op;
      prev1 = 5'd1;
      prev2 = 5'd2;
      repeat (n) begin
         rd = pickReg(8) + 5'd1;
         op = isaPkg::OpAdd | 6'($unsigned($random(seed)) & 1);
         if ($random(seed) & 1) begin
            issue(encR(op, rd, prev1, prev2));  // Distance one on A and two on B
         end else begin
            issue(encR(op, rd, prev2, prev1));
         end
         prev2 = prev1;
         prev1 = rd;
      end
   endtask

   task automatic prefixConst(input int n);
      logic [4:0] rd;
      repeat (n) begin
         rd = pickReg(8) + 5'd9;
         loadConst(rd, $random(seed));
         issue(encI(isaPkg::OpAdd | 6'o10, rd + 5'd1, rd, 16'h8000 | 16'($random(seed))));
      end
   endtask

   task automatic memPair(input int n);
      logic [4:0]  base;
      logic [4:0]  dataReg;
      logic [4:0]  dst;
      logic [15:0] off;
      repeat (n) begin
         base    = pickReg(8) + 5'd1;
         dataReg = pickReg(8) + 5'd1;
         dst     = pickReg(8) + 5'd9;
         off     = 16'($random(seed));
         issue(encI(isaPkg::OpAdd | 6'o10, dataReg, dataReg, 16'($random(seed))));
         issue(encI(isaPkg::OpStoreWord, dataReg, base, off));  // Store data forwarded
         issue(encI(isaPkg::OpLoadWord | 6'o10, dst, base, off));
         if ($random(seed) & 1) begin
            issue(encR(isaPkg::OpAdd, pickReg(8) + 5'd1, dst, pickReg(9)));
         end else begin
            issue(encR(isaPkg::OpAdd, pickReg(8) + 5'd1, pickReg(9), dst));
         end
      end
   endtask

   task automatic startTest(input string name);
      testName  = name;
      errMark   = errCount;
      checkMark = checkCount;
   endtask

   task automatic endTest();
      int t;
      t = 0;
      while (expQ.size() > 0 && t < 20) begin
         issue(32'd0);  // add r0 retires without a write
         t++;
      end
      if (expQ.size() > 0) begin
         $display("Timeout in %s: %0d write-backs never appeared", testName, expQ.size());
         timedOut = 1'b1;
         errCount++;
         expQ.delete();
      end
      testCount++;
      $display("Test %s: %0d write-backs checked, %0d errors", testName,
               checkCount - checkMark, errCount - errMark);
   endtask

   initial begin
      grst       = 1'b1;
      advance    = 1'b0;
      instr      = '0;
      issueMem   = 2'b00;
      stallOn    = 1'b0;
      timedOut   = 1'b0;
      prefixOn   = 1'b0;
      prefixHi   = '0;
      errCount   = 0;
      checkCount = 0;
      testCount  = 0;
      for (int i = 0; i < 32; i++) begin
         regModel[i] = '0;
      end
      repeat (2) @(negedge gclk);
      grst = 1'b0;

      startTest("arith");
      for (int r = 1; r <= 8; r++) begin
         loadConst(5'(r), $random(seed));
      end
      randArith(24);
      endTest();

      startTest("logic_shift");
      randLogic(24);
      endTest();

      startTest("forwarding");
      depChain(16);
      endTest();

      startTest("imm_prefix");
      prefixConst(4);
      endTest();

      startTest("load_store");
      memPair(4);
      endTest();

      startTest("stalls");
      stallOn = 1'b1;
      randArith(8);
      randLogic(8);
      depChain(8);
      prefixConst(2);
      memPair(2);
      endTest();
      stallOn = 1'b0;
      advance = 1'b0;

      $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
      if (errCount == 0 && !timedOut) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/execCore_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module execCore_chk (
   input logic                gclk,
   input logic                grst,
   input logic                advance,
   input pipePkg::operandSelT srcSel,
   input pipePkg::operandSelT tgtSel,
   input pipePkg::dstKindT    dstKind,
   input isaPkg::regIdxT      rw,
   input isaPkg::opcodeT      opc,
   input logic                valid
);

   // Registered selects come out of reset cleared
   resetClears: assert property (@(posedge gclk)
      grst |=> (srcSel == pipePkg::SelReg) && (tgtSel == pipePkg::SelReg) &&
               (dstKind == pipePkg::DstNone) && (rw == '0) && !valid)
      else $error("Decode selects not cleared after reset");

   // A forward needs a real destination one ahead
   fwdNeedsDest: assert property (@(posedge gclk) disable iff (grst)
      advance && (rw == '0) |=>
      (srcSel != pipePkg::SelFwd) && (srcSel != pipePkg::SelRam) &&
      (tgtSel != pipePkg::SelFwd) && (tgtSel != pipePkg::SelRam))
      else $error("Forward select chosen against r0");

   // Stores and the prefix leave no destination behind
   noneHasNoDest: assert property (@(posedge gclk) disable iff (grst)
      valid && ((opc == isaPkg::OpStoreWord) || (opc == isaPkg::OpImm))
      |-> (dstKind == pipePkg::DstNone) && (rw == '0))
      else $error("Instruction without result still names a write-back register");

endmodule

bind pipeCtrl execCore_chk uChk (
   .gclk    (gclk),
   .grst    (grst),
   .advance (advance),
   .srcSel  (bus.srcSel),
   .tgtSel  (bus.tgtSel),
   .dstKind (bus.dstKind),
   .rw      (bus.rw),
   .opc     (bus.opc),
   .valid   (bus.valid)
);

`default_nettype wire

// ==== src/execCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module execCore #(
   parameter int RamAddrBits = 8
) (
   input  logic        gclk,
   input  logic        grst,
   input  logic        advance,
   input  logic [31:0] instr,
   output logic        wbValid,
   output logic [4:0]  wbReg,
   output logic [31:0] wbData,
   output logic        memAccess,
   output logic        memWrite
);

   isaPkg::wordT           rdA;
   isaPkg::wordT           rdB;
   isaPkg::wordT           ramData;
   isaPkg::wordT           memWdata;
   logic [RamAddrBits-1:0] memAddr;

   ctrlBus bus ();

   pipeCtrl uPipeCtrl (
      .gclk    (gclk),
      .grst    (grst),
      .advance (advance),
      .instr   (instr),
      .bus     (bus)
   );

   // Execute reads at the registered operand fields
   regFile uRegFile (
      .gclk (gclk),
      .grst (grst),
      .we   (wbValid),
      .wa   (wbReg),
      .ra   (bus.ra),
      .rb   (bus.rb),
      .wd   (wbData),
      .rdA  (rdA),
      .rdB  (rdB)
   );

   execUnit #(.RamAddrBits(RamAddrBits)) uExecUnit (
      .gclk      (gclk),
      .grst      (grst),
      .advance   (advance),
      .bus       (bus),
      .rdA       (rdA),
      .rdB       (rdB),
      .ramData   (ramData),
      .wbValid   (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .memAccess (memAccess),
      .memWrite  (memWrite),
      .memAddr   (memAddr),
      .memWdata  (memWdata)
   );

   dataRam #(.RamAddrBits(RamAddrBits)) uDataRam (
      .gclk   (gclk),
      .access (memAccess),
      .write  (memWrite),
      .addr   (memAddr),
      .wdata  (memWdata),
      .rdata  (ramData)
   );

endmodule

`default_nettype wire

// ==== src/dataRam.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataRam #(
   parameter int RamAddrBits = 8
) (
   input  logic                   gclk,
   input  logic                   access,
   input  logic                   write,
   input  logic [RamAddrBits-1:0] addr,
   input  isaPkg::wordT           wdata,
   output isaPkg::wordT           rdata
);

   isaPkg::wordT mem [2 ** RamAddrBits];

   // Read data holds until the next access
   always_ff @(posedge gclk) begin
      if (access) begin
         if (write) begin
            mem[addr] <= wdata;
         end else begin
            rdata <= mem[addr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execUnit #(
   parameter int RamAddrBits = 8
) (
   input  logic                   gclk,
   input  logic                   grst,
   input  logic                   advance,
   ctrlBus.exec                   bus,
   input  isaPkg::wordT           rdA,
   input  isaPkg::wordT           rdB,
   input  isaPkg::wordT           ramData,
   output logic                   wbValid,
   output isaPkg::regIdxT         wbReg,
   output isaPkg::wordT           wbData,
   output logic                   memAccess,
   output logic                   memWrite,
   output logic [RamAddrBits-1:0] memAddr,
   output isaPkg::wordT           memWdata
);

   isaPkg::wordT     opA;
   isaPkg::wordT     opB;
   isaPkg::wordT     immWord;
   isaPkg::wordT     sum;
   isaPkg::wordT     logicRes;
   isaPkg::wordT     shiftRes;
   isaPkg::wordT     aluRes;
   isaPkg::wordT     stageWord;
   logic             immPending;
   isaPkg::immT      immHigh;
   logic             isLoad;
   logic             isStore;
   logic             stValid;
   isaPkg::regIdxT   stReg;
   pipePkg::dstKindT stKind;
   isaPkg::wordT     stData;

   // Prefix supplies the upper half, else sign extension
   assign immWord = immPending ? {immHigh, bus.imm} : {{16{bus.imm[15]}}, bus.imm};

   // Result of the instruction one ahead, now in the stage register
   assign stageWord = (stKind == pipePkg::DstRam) ? ramData : stData;

   always_comb begin
      unique case (bus.srcSel)
         pipePkg::SelFwd: opA = stData;
         pipePkg::SelRam: opA = ramData;
         default:         opA = rdA;
      endcase
      unique case (bus.tgtSel)
         pipePkg::SelFwd: opB = stData;
         pipePkg::SelRam: opB = ramData;
         pipePkg::SelImm: opB = immWord;
         default:         opB = rdB;
      endcase
   end

   assign sum = bus.opc[0] ? (opB - opA) : (opA + opB);  // rsub is B minus A

   always_comb begin
      unique case (bus.opc[1:0])
         2'b00:   logicRes = opA | opB;
         2'b01:   logicRes = opA & opB;
         2'b10:   logicRes = opA ^ opB;
         default: logicRes = opA & ~opB;
      endcase
   end

   assign shiftRes = {(bus.imm[6:5] == isaPkg::ShiftArith) & opA[31], opA[31:1]};

   assign aluRes = (bus.aluOp == pipePkg::AluLogic) ? logicRes :
                   (bus.aluOp == pipePkg::AluShift) ? shiftRes :
                                                      sum;

   // RAM samples on the advancing edge, so load data is ready for the next instruction
   assign isLoad    = bus.dstKind == pipePkg::DstRam;
   assign isStore   = bus.opc == isaPkg::OpStoreWord;
   assign memAccess = advance && bus.valid && (isLoad || isStore);
   assign memWrite  = isStore;
   assign memAddr   = aluRes[RamAddrBits+1:2];
   assign memWdata  = (stValid && (stReg == bus.rb)) ? stageWord : rdB;

   always_ff @(posedge gclk) begin
      if (grst) begin
         stValid    <= 1'b0;
         stKind     <= pipePkg::DstNone;
         immPending <= 1'b0;
      end else if (advance) begin
         stValid <= bus.valid && (bus.dstKind != pipePkg::DstNone) && (bus.rw != '0);
         stKind  <= bus.dstKind;
         if (bus.valid) begin
            immPending <= bus.opc == isaPkg::OpImm;  // Lasts one instruction
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (advance) begin
         stReg  <= bus.rw;
         stData <= aluRes;
         wbReg  <= stReg;
         wbData <= stageWord;
         if (bus.opc == isaPkg::OpImm) begin
            immHigh <= bus.imm;
         end
      end
   end

   // One pulse per retired write
   always_ff @(posedge gclk) begin
      if (grst) begin
         wbValid <= 1'b0;
      end else begin
         wbValid <= advance && stValid;
      end
   end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
   input  logic           gclk,
   input  logic           grst,
   input  logic           we,
   input  isaPkg::regIdxT wa,
   input  isaPkg::regIdxT ra,
   input  isaPkg::regIdxT rb,
   input  isaPkg::wordT   wd,
   output isaPkg::wordT   rdA,
   output isaPkg::wordT   rdB
);

   isaPkg::wordT regs [isaPkg::NumRegs];

   // r0 is cleared here and never written
   always_ff @(posedge gclk) begin
      if (grst) begin
         for (int i = 0; i < isaPkg::NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wa != '0)) begin
         regs[wa] <= wd;
      end
   end

   // Write-through covers the instruction two behind
   assign rdA = (we && (wa == ra) && (ra != '0)) ? wd : regs[ra];
   assign rdB = (we && (wa == rb) && (rb != '0)) ? wd : regs[rb];

endmodule

`default_nettype wire

// ==== src/pipeCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeCtrl (
   input  logic          gclk,
   input  logic          grst,
   input  logic          advance,
   input  isaPkg::instrT instr,
   ctrlBus.ctrl          bus
);

   isaPkg::opcodeT      opc;
   isaPkg::regIdxT      rd;
   isaPkg::regIdxT      ra;
   isaPkg::regIdxT      rb;
   isaPkg::immT         imm;
   logic                isAdd;
   logic                isLogic;
   logic                isShift;
   logic                isLoad;
   logic                isStore;
   logic                hazardLive;
   logic                fwdAluA;
   logic                fwdAluB;
   logic                fwdRamA;
   logic                fwdRamB;
   pipePkg::operandSelT decSrc;
   pipePkg::operandSelT decTgt;
   pipePkg::aluOpT      decAlu;
   pipePkg::dstKindT    decDst;
   isaPkg::regIdxT      decRw;
   isaPkg::regIdxT      decRb;

   assign {opc, rd, ra, rb} = instr[31:11];
   assign imm = instr[15:0];

   // Operation groups
   assign isAdd   = {opc[5:4], opc[2:1]} == {isaPkg::OpAdd[5:4], isaPkg::OpAdd[2:1]};
   assign isLogic = {opc[5:4], opc[2]} == {isaPkg::OpLogic[5:4], isaPkg::OpLogic[2]};
   assign isShift = opc == isaPkg::OpShift;
   assign isLoad  = {opc[5:4], opc[2:0]} ==
                    {isaPkg::OpLoadWord[5:4], isaPkg::OpLoadWord[2:0]};
   assign isStore = opc == isaPkg::OpStoreWord;

   assign decDst = (isAdd || isLogic || isShift) ? pipePkg::DstAlu :
                   isLoad                        ? pipePkg::DstRam :
                                                   pipePkg::DstNone;

   assign decAlu = isLogic ? pipePkg::AluLogic :
                   isShift ? pipePkg::AluShift :
                             pipePkg::AluAdd;

   assign decRw = (decDst != pipePkg::DstNone) ? rd : '0;  // Nothing to forward otherwise
   assign decRb = isStore ? rd : rb;                        // Store data rides the B port

   // Distance one, against the instruction now in execute
   assign hazardLive = bus.valid && (bus.rw != '0);
   assign fwdAluA = hazardLive && (bus.dstKind == pipePkg::DstAlu) && (bus.rw == ra);
   assign fwdAluB = hazardLive && (bus.dstKind == pipePkg::DstAlu) && (bus.rw == rb);
   assign fwdRamA = hazardLive && (bus.dstKind == pipePkg::DstRam) && (bus.rw == ra);
   assign fwdRamB = hazardLive && (bus.dstKind == pipePkg::DstRam) && (bus.rw == rb);

   assign decSrc = fwdRamA ? pipePkg::SelRam :
                   fwdAluA ? pipePkg::SelFwd :
                             pipePkg::SelReg;

   assign decTgt = opc[3]  ? pipePkg::SelImm :
                   fwdRamB ? pipePkg::SelRam :
                   fwdAluB ? pipePkg::SelFwd :
                             pipePkg::SelReg;

   always_ff @(posedge gclk) begin
      if (grst) begin
         bus.srcSel  <= pipePkg::SelReg;
         bus.tgtSel  <= pipePkg::SelReg;
         bus.aluOp   <= pipePkg::AluAdd;
         bus.dstKind <= pipePkg::DstNone;
         bus.rw      <= '0;
         bus.ra      <= '0;
         bus.rb      <= '0;
         bus.opc     <= '0;
         bus.imm     <= '0;
         bus.valid   <= 1'b0;
      end else if (advance) begin
         bus.srcSel  <= decSrc;
         bus.tgtSel  <= decTgt;
         bus.aluOp   <= decAlu;
         bus.dstKind <= decDst;
         bus.rw      <= decRw;
         bus.ra      <= ra;
         bus.rb      <= decRb;
         bus.opc     <= opc;
         bus.imm     <= imm;
         bus.valid   <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== src/ctrlBus.sv ====
`timescale 1ns/10ps
`default_nettype none

interface ctrlBus;

   pipePkg::operandSelT srcSel;
   pipePkg::operandSelT tgtSel;
   pipePkg::aluOpT      aluOp;
   pipePkg::dstKindT    dstKind;
   isaPkg::regIdxT      rw;
   isaPkg::regIdxT      ra;
   isaPkg::regIdxT      rb;     // rD for a store
   isaPkg::opcodeT      opc;
   isaPkg::immT         imm;
   logic                valid;  // Slot holds an accepted instruction

   modport ctrl (
      output srcSel, tgtSel, aluOp, dstKind, rw, ra, rb, opc, imm, valid
   );

   modport exec (
      input srcSel, tgtSel, aluOp, dstKind, rw, ra, rb, opc, imm, valid
   );

endinterface

`default_nettype wire

// ==== src/pipePkg.sv ====
`default_nettype none

package pipePkg;

   // Operand source
   typedef logic [1:0] operandSelT;

   localparam operandSelT SelReg = 2'd0;  // Register file port
   localparam operandSelT SelFwd = 2'd1;  // ALU result one instruction back
   localparam operandSelT SelRam = 2'd2;  // Load data one instruction back
   localparam operandSelT SelImm = 2'd3;  // Second operand only

   // ALU operation group
   typedef logic [2:0] aluOpT;

   localparam aluOpT AluAdd   = 3'd0;  // Also computes load and store addresses
   localparam aluOpT AluLogic = 3'd1;
   localparam aluOpT AluShift = 3'd2;

   // Destination of the result
   typedef logic [1:0] dstKindT;

   localparam dstKindT DstAlu  = 2'd0;
   localparam dstKindT DstRam  = 2'd2;
   localparam dstKindT DstNone = 2'd3;

endpackage

`default_nettype wire

// ==== src/isaPkg.sv ====
`default_nettype none

package isaPkg;

   localparam int OpcBits  = 6;
   localparam int RegBits  = 5;
   localparam int ImmBits  = 16;
   localparam int WordBits = 32;
   localparam int NumRegs  = 2 ** RegBits;

   typedef logic [OpcBits-1:0]  opcodeT;
   typedef logic [RegBits-1:0]  regIdxT;
   typedef logic [WordBits-1:0] wordT;
   typedef logic [ImmBits-1:0]  immT;
   typedef logic [WordBits-1:0] instrT;

   // Add group base
   // bit 3 picks the immediate form, bit 0 reverse subtract
   localparam opcodeT OpAdd       = 6'o00;
   localparam opcodeT OpLogic     = 6'o40;  // or, and, xor, andn in bits 1:0
   localparam opcodeT OpShift     = 6'o44;  // Kind in immediate bits 6:5
   localparam opcodeT OpImm       = 6'o54;  // Upper half for the next immediate
   localparam opcodeT OpLoadWord  = 6'o62;  // Bit 3 gives lwi
   localparam opcodeT OpStoreWord = 6'o76;  // swi only, rD carries the data

   // Shift kinds in immediate bits 6:5
   localparam logic [1:0] ShiftArith = 2'b00;
   localparam logic [1:0] ShiftCarry = 2'b01;  // No carry flag here, shifts in zero
   localparam logic [1:0] ShiftLogic = 2'b10;

endpackage

`default_nettype wire
